/* hw/fpsu_defs.svh */
// width, latency and operand select macros for the SIMD execution unit.
`ifndef FPSU_DEFS_SVH
`define FPSU_DEFS_SVH

// one signed lane.
`define FPSU_LANE_W 16

// one half word holds two lanes.
`define FPSU_HALF_W 32

// completion tag returned with every op.
`define FPSU_TAG_W 8

// cycles from issue to done.
`define FPSU_LAT 2

// operand select codes.
`define FPSU_SEL_REG  2'd0
`define FPSU_SEL_FWD0 2'd1
`define FPSU_SEL_FWD1 2'd2
`define FPSU_SEL_OWN  2'd3

`endif

/* hw/fpsu_pkg.sv */
// lane, half word, tag and op types shared by the SIMD execution unit.
`default_nettype none

`include "fpsu_defs.svh"

package fpsu_pkg;

  // lanes per half word.
  localparam int lanes = `FPSU_HALF_W / `FPSU_LANE_W;

  typedef logic signed [`FPSU_LANE_W-1:0] lane_t;

  // lane 0 sits in the low bits.
  typedef logic [`FPSU_HALF_W-1:0] half_t;

  typedef logic [`FPSU_TAG_W-1:0] tag_t;

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_ADDS  = 3'd2,
    OP_MAX   = 3'd3,
    OP_MIN   = 3'd4,
    OP_XCHG  = 3'd5,
    OP_PASSB = 3'd6
  } op_e;

endpackage

`default_nettype wire

/* hw/fpsu_delay.sv */
// fpsu_delay: valid-tracked shift line for an arbitrary payload type.
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_defs.svh"

module fpsu_delay #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = `FPSU_LAT
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic [depth-1:0] vld_q;
  payload_t         data_q [depth];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= in_valid;
      for (int i = 1; i < depth; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // payload only moves behind a valid bit.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      data_q[0] <= in_data;
    end
    for (int i = 1; i < depth; i++) begin
      if (vld_q[i-1]) begin
        data_q[i] <= data_q[i-1];
      end
    end
  end

  assign out_valid = vld_q[depth-1];
  assign out_data  = data_q[depth-1];

  a_out_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(out_valid));

endmodule

`default_nettype wire

/* hw/fpsu_opnd_sel.sv */
// fpsu_opnd_sel: four-way operand forwarding mux with own-result bypass.
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_defs.svh"

module fpsu_opnd_sel (
  input  logic            clk,
  input  logic            chk_en,
  input  logic [1:0]      sel,
  input  fpsu_pkg::half_t reg_val,
  input  fpsu_pkg::half_t fwd0,
  input  fpsu_pkg::half_t fwd1,
  input  fpsu_pkg::half_t own,
  output fpsu_pkg::half_t val
);

  always_comb begin
    case (sel)
      `FPSU_SEL_REG:  val = reg_val;
      `FPSU_SEL_FWD0: val = fwd0;
      `FPSU_SEL_FWD1: val = fwd1;
      // last completed result of this half.
      `FPSU_SEL_OWN:  val = own;
      default:        val = reg_val;
    endcase
  end

  // select only matters on an issue cycle.
  a_sel_known: assert property (@(posedge clk)
    chk_en |-> !$isunknown(sel));

endmodule

`default_nettype wire

/* hw/fpsu_lane_alu.sv */
// fpsu_lane_alu: two-lane signed 16-bit SIMD arithmetic with saturation flags.
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_defs.svh"

module fpsu_lane_alu (
  input  fpsu_pkg::op_e             op,
  input  fpsu_pkg::half_t           a,
  input  fpsu_pkg::half_t           b,
  input  fpsu_pkg::half_t           xchg,
  output fpsu_pkg::half_t           res,
  output logic [fpsu_pkg::lanes-1:0] sat
);

  localparam int w = `FPSU_LANE_W;

  // clamp limits for the saturating add.
  localparam fpsu_pkg::lane_t lane_max = {1'b0, {(w-1){1'b1}}};
  localparam fpsu_pkg::lane_t lane_min = {1'b1, {(w-1){1'b0}}};

  always_comb begin
    fpsu_pkg::lane_t la;
    fpsu_pkg::lane_t lb;
    fpsu_pkg::lane_t lx;
    fpsu_pkg::lane_t lr;
    logic [w:0]      wide;

    res = '0;
    sat = '0;
    for (int i = 0; i < fpsu_pkg::lanes; i++) begin
      la = a[i*w +: w];
      lb = b[i*w +: w];
      lx = xchg[i*w +: w];
      // sign-extended sum, top two bits show overflow.
      wide = {la[w-1], la} + {lb[w-1], lb};
      case (op)
        fpsu_pkg::OP_ADD: lr = la + lb;
        fpsu_pkg::OP_SUB: lr = la - lb;
        fpsu_pkg::OP_ADDS: begin
          if (wide[w:w-1] == 2'b01) begin
            lr     = lane_max;
            sat[i] = 1'b1;
          end else if (wide[w:w-1] == 2'b10) begin
            lr     = lane_min;
            sat[i] = 1'b1;
          end else begin
            lr = wide[w-1:0];
          end
        end
        fpsu_pkg::OP_MAX:   lr = (la > lb) ? la : lb;
        fpsu_pkg::OP_MIN:   lr = (la < lb) ? la : lb;
        // other half's A operand.
        fpsu_pkg::OP_XCHG:  lr = lx;
        fpsu_pkg::OP_PASSB: lr = lb;
        default:            lr = '0;
      endcase
      res[i*w +: w] = lr;
    end
  end

endmodule

`default_nettype wire

/* hw/fpsu_half.sv */
// fpsu_half: operand select, issue register, lane ALU, result and tag pipeline.
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_defs.svh"

module fpsu_half (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       en,
  input  fpsu_pkg::op_e              op,
  input  fpsu_pkg::tag_t             tag,
  input  fpsu_pkg::half_t            a,
  input  fpsu_pkg::half_t            b,
  input  logic [1:0]                 sel_a,
  input  logic [1:0]                 sel_b,
  input  fpsu_pkg::half_t            fwd0,
  input  fpsu_pkg::half_t            fwd1,
  input  fpsu_pkg::half_t            xchg_in,
  output fpsu_pkg::half_t            xchg_out,
  output fpsu_pkg::half_t            res,
  output logic [fpsu_pkg::lanes-1:0] sat,
  output logic                       done,
  output fpsu_pkg::tag_t             done_tag
);

  fpsu_pkg::half_t            opa;
  fpsu_pkg::half_t            opb;
  fpsu_pkg::half_t            opa_q;
  fpsu_pkg::half_t            opb_q;
  fpsu_pkg::half_t            xchg_q;
  fpsu_pkg::op_e              op_q;
  logic                       en_q;
  fpsu_pkg::half_t            alu_res;
  logic [fpsu_pkg::lanes-1:0] alu_sat;
  fpsu_pkg::tag_t             tag_d;

  fpsu_opnd_sel a_sel (
    .clk(clk), .chk_en(en), .sel(sel_a), .reg_val(a),
    .fwd0(fwd0), .fwd1(fwd1), .own(res), .val(opa)
  );

  fpsu_opnd_sel b_sel (
    .clk(clk), .chk_en(en), .sel(sel_b), .reg_val(b),
    .fwd0(fwd0), .fwd1(fwd1), .own(res), .val(opb)
  );

  // selected A goes to the other half for exchange.
  assign xchg_out = opa;

  // stage 1, issue register.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q <= 1'b0;
    end else begin
      en_q <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      opa_q  <= opa;
      opb_q  <= opb;
      xchg_q <= xchg_in;
      op_q   <= op;
    end
  end

  fpsu_lane_alu alu (
    .op(op_q), .a(opa_q), .b(opb_q), .xchg(xchg_q), .res(alu_res), .sat(alu_sat)
  );

  // stage 2, result held while this half is idle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res <= '0;
      sat <= '0;
    end else if (en_q) begin
      res <= alu_res;
      sat <= alu_sat;
    end
  end

  fpsu_delay #(.payload_t(fpsu_pkg::tag_t)) tag_line (
    .clk(clk), .rst_n(rst_n), .in_valid(en), .in_data(tag),
    .out_valid(done), .out_data(tag_d)
  );

  // zero when idle so the top can OR the halves.
  assign done_tag = done ? tag_d : '0;

  a_done_has_issue: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(en, `FPSU_LAT));

endmodule

`default_nettype wire

/* hw/fpsu_both.sv */
// two SIMD halves, crossed exchange wires and merged return port.
`timescale 1ns/1ps
`default_nettype none

module fpsu_both (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [1:0]                   en,
  input  fpsu_pkg::op_e                op,
  input  fpsu_pkg::tag_t               tag,
  input  fpsu_pkg::half_t              a_lo,
  input  fpsu_pkg::half_t              b_lo,
  input  fpsu_pkg::half_t              a_hi,
  input  fpsu_pkg::half_t              b_hi,
  input  logic [1:0]                   sel_a,
  input  logic [1:0]                   sel_b,
  input  fpsu_pkg::half_t              fwd_lo0,
  input  fpsu_pkg::half_t              fwd_lo1,
  input  fpsu_pkg::half_t              fwd_hi0,
  input  fpsu_pkg::half_t              fwd_hi1,
  output fpsu_pkg::half_t              res_lo,
  output fpsu_pkg::half_t              res_hi,
  output logic [2*fpsu_pkg::lanes-1:0] sat,
  output fpsu_pkg::tag_t               ret_tag,
  output logic                         ret_en
);

  fpsu_pkg::half_t            xchg_lo;
  fpsu_pkg::half_t            xchg_hi;
  logic [fpsu_pkg::lanes-1:0] sat_lo;
  logic [fpsu_pkg::lanes-1:0] sat_hi;
  logic                       done_lo;
  logic                       done_hi;
  fpsu_pkg::tag_t             tag_lo;
  fpsu_pkg::tag_t             tag_hi;

  // exchange wires cross between the halves.
  fpsu_half lo_half (
    .clk(clk), .rst_n(rst_n), .en(en[0]), .op(op), .tag(tag),
    .a(a_lo), .b(b_lo), .sel_a(sel_a), .sel_b(sel_b),
    .fwd0(fwd_lo0), .fwd1(fwd_lo1), .xchg_in(xchg_hi), .xchg_out(xchg_lo),
    .res(res_lo), .sat(sat_lo), .done(done_lo), .done_tag(tag_lo)
  );

  fpsu_half hi_half (
    .clk(clk), .rst_n(rst_n), .en(en[1]), .op(op), .tag(tag),
    .a(a_hi), .b(b_hi), .sel_a(sel_a), .sel_b(sel_b),
    .fwd0(fwd_hi0), .fwd1(fwd_hi1), .xchg_in(xchg_lo), .xchg_out(xchg_hi),
    .res(res_hi), .sat(sat_hi), .done(done_hi), .done_tag(tag_hi)
  );

  // idle halves drive zero so OR merges them.
  assign ret_en  = done_lo | done_hi;
  assign ret_tag = tag_lo | tag_hi;
  assign sat     = {sat_hi, sat_lo};

endmodule

`default_nettype wire

/* sim/fpsu_tb.sv */
// directed testbench with clock, reset, lane reference model, return monitor and report.
`timescale 1ns/1ps
`default_nettype none

`include "fpsu_defs.svh"

module fpsu_tb;

  // twice the length of about 30 ops at 3 to 4 cycles each plus reset.
  localparam int cycle_limit = 200;
  localparam int ret_wait    = 8;

  logic                  clk;
  logic                  rst_n;
  logic [1:0]            en;
  fpsu_pkg::op_e         op;
  fpsu_pkg::tag_t        tag;
  fpsu_pkg::half_t       a_lo;
  fpsu_pkg::half_t       b_lo;
  fpsu_pkg::half_t       a_hi;
  fpsu_pkg::half_t       b_hi;
  logic [1:0]            sel_a;
  logic [1:0]            sel_b;
  fpsu_pkg::half_t       fwd_lo0;
  fpsu_pkg::half_t       fwd_lo1;
  fpsu_pkg::half_t       fwd_hi0;
  fpsu_pkg::half_t       fwd_hi1;
  fpsu_pkg::half_t       res_lo;
  fpsu_pkg::half_t       res_hi;
  logic [3:0]            sat;
  fpsu_pkg::tag_t        ret_tag;
  logic                  ret_en;

  int                    seed;
  int                    errors;
  int                    checks;
  int                    failed_tests;
  int                    cycle_cnt;

  // model of the last completed result per half.
  fpsu_pkg::half_t       exp_lo;
  fpsu_pkg::half_t       exp_hi;
  logic [3:0]            exp_sat;

  // expected returns in issue order.
  fpsu_pkg::tag_t        q_tag[$];
  fpsu_pkg::half_t       q_lo[$];
  fpsu_pkg::half_t       q_hi[$];
  logic [3:0]            q_sat[$];
  int                    q_cyc[$];

  fpsu_both UUT (
    .clk(clk), .rst_n(rst_n), .en(en), .op(op), .tag(tag),
    .a_lo(a_lo), .b_lo(b_lo), .a_hi(a_hi), .b_hi(b_hi), .sel_a(sel_a), .sel_b(sel_b),
    .fwd_lo0(fwd_lo0), .fwd_lo1(fwd_lo1), .fwd_hi0(fwd_hi0), .fwd_hi1(fwd_hi1),
    .res_lo(res_lo), .res_hi(res_hi), .sat(sat), .ret_tag(ret_tag), .ret_en(ret_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run went past %0d cycles", cycle_limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic fpsu_pkg::half_t rand_word();
    return $random(seed);
  endfunction

  // one lane by the op rules.
  // s flags a clamp.
  function automatic fpsu_pkg::lane_t model_lane(input fpsu_pkg::op_e o,
      input fpsu_pkg::lane_t x, y, xc, output logic s);
    int              sum;
    fpsu_pkg::lane_t r;
    s   = 1'b0;
    sum = int'(x) + int'(y);
    case (o)
      fpsu_pkg::OP_ADD: r = sum[`FPSU_LANE_W-1:0];
      fpsu_pkg::OP_SUB: r = x - y;
      fpsu_pkg::OP_ADDS: begin
        if (sum > 32767) begin
          r = 16'sh7fff;
          s = 1'b1;
        end else if (sum < -32768) begin
          r = 16'sh8000;
          s = 1'b1;
        end else begin
          r = sum[`FPSU_LANE_W-1:0];
        end
      end
      fpsu_pkg::OP_MAX:   r = (int'(x) >= int'(y)) ? x : y;
      fpsu_pkg::OP_MIN:   r = (int'(x) <= int'(y)) ? x : y;
      fpsu_pkg::OP_XCHG:  r = xc;
      fpsu_pkg::OP_PASSB: r = y;
      default:            r = '0;
    endcase
    return r;
  endfunction

  function automatic fpsu_pkg::half_t model_half(input fpsu_pkg::op_e o,
      input fpsu_pkg::half_t x, y, xc, output logic [1:0] s);
    fpsu_pkg::half_t r;
    logic            s_l;
    for (int i = 0; i < 2; i++) begin
      r[i*16 +: 16] = model_lane(o, x[i*16 +: 16], y[i*16 +: 16], xc[i*16 +: 16], s_l);
      s[i] = s_l;
    end
    return r;
  endfunction

  function automatic fpsu_pkg::half_t select_operand(input logic [1:0] s,
      input fpsu_pkg::half_t r, f0, f1, own);
    case (s)
      `FPSU_SEL_FWD0: return f0;
      `FPSU_SEL_FWD1: return f1;
      `FPSU_SEL_OWN:  return own;
      default:        return r;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // drives one op and records what it should return.
  task automatic issue(input logic [1:0] e, input fpsu_pkg::op_e o, input fpsu_pkg::tag_t t,
      input fpsu_pkg::half_t al, bl, ah, bh,
      input logic [1:0] sa = `FPSU_SEL_REG, input logic [1:0] sb = `FPSU_SEL_REG);
    fpsu_pkg::half_t pal;
    fpsu_pkg::half_t pbl;
    fpsu_pkg::half_t pah;
    fpsu_pkg::half_t pbh;
    logic [1:0]      s_lo;
    logic [1:0]      s_hi;
    @(posedge clk);
    #2;
    en    = e;
    op    = o;
    tag   = t;
    a_lo  = al;
    b_lo  = bl;
    a_hi  = ah;
    b_hi  = bh;
    sel_a = sa;
    sel_b = sb;
    pal = select_operand(sa, al, fwd_lo0, fwd_lo1, exp_lo);
    pbl = select_operand(sb, bl, fwd_lo0, fwd_lo1, exp_lo);
    pah = select_operand(sa, ah, fwd_hi0, fwd_hi1, exp_hi);
    pbh = select_operand(sb, bh, fwd_hi0, fwd_hi1, exp_hi);
    if (e[0]) begin
      exp_lo       = model_half(o, pal, pbl, pah, s_lo);
      exp_sat[1:0] = s_lo;
    end
    if (e[1]) begin
      exp_hi       = model_half(o, pah, pbh, pal, s_hi);
      exp_sat[3:2] = s_hi;
    end
    q_tag.push_back(t);
    q_lo.push_back(exp_lo);
    q_hi.push_back(exp_hi);
    q_sat.push_back(exp_sat);
    q_cyc.push_back(cycle_cnt);
  endtask

  // drops en and waits until every issued op has returned.
  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk);
    #2;
    en = 2'b00;
    while (q_tag.size() != 0 && n < ret_wait) begin
      @(posedge clk);
      #2;
      n++;
    end
    assert (q_tag.size() == 0) else begin
      $display("%0t ns: %0d issued ops never returned", $time, q_tag.size());
      errors++;
      q_tag.delete();
      q_lo.delete();
      q_hi.delete();
      q_sat.delete();
      q_cyc.delete();
    end
  endtask

  // every return is matched against the oldest expected op.
  always @(posedge clk) begin
    #1;
    if (rst_n && ret_en) begin
      assert (q_tag.size() != 0) else begin
        $display("%0t ns: return with tag %h came without an issued op", $time, ret_tag);
        errors++;
      end
      if (q_tag.size() != 0) begin
        check_val("ret_tag", 32'(ret_tag), 32'(q_tag.pop_front()));
        check_val("res_lo", res_lo, q_lo.pop_front());
        check_val("res_hi", res_hi, q_hi.pop_front());
        check_val("sat", 32'(sat), 32'(q_sat.pop_front()));
        check_val("latency", cycle_cnt - q_cyc.pop_front(), `FPSU_LAT);
      end
    end
  end

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%s: passed", name);
    end else begin
      failed_tests++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_add_sub();
    int e0;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      issue(2'b11, (i % 2) ? fpsu_pkg::OP_SUB : fpsu_pkg::OP_ADD, 8'h10 + 8'(i),
            rand_word(), rand_word(), rand_word(), rand_word());
      wait_idle();
    end
    report_test("test 1 add/sub", e0);
  endtask

  task automatic test_sat_add();
    int e0;
    e0 = errors;
    // lo overflows both ways and hi stays in range.
    issue(2'b11, fpsu_pkg::OP_ADDS, 8'h20, 32'h8100_7000, 32'h9000_2000,
          32'h7fff_1234, 32'hffff_0100);
    wait_idle();
    issue(2'b11, fpsu_pkg::OP_ADDS, 8'h21, 32'h8000_7fff, 32'hffff_0001,
          32'h0001_7ffe, 32'h7fff_0001);
    wait_idle();
    issue(2'b11, fpsu_pkg::OP_ADDS, 8'h22, rand_word(), rand_word(), rand_word(), rand_word());
    wait_idle();
    report_test("test 2 saturating add", e0);
  endtask

  task automatic test_max_min();
    int e0;
    e0 = errors;
    issue(2'b11, fpsu_pkg::OP_MAX, 8'h30, 32'hfff0_0005, 32'h0003_fffb,
          32'h8000_1234, 32'h7fff_1234);
    wait_idle();
    issue(2'b11, fpsu_pkg::OP_MIN, 8'h31, 32'hfff0_0005, 32'h0003_fffb,
          32'h8000_1234, 32'h7fff_1234);
    wait_idle();
    issue(2'b11, fpsu_pkg::OP_MAX, 8'h32, rand_word(), rand_word(), rand_word(), rand_word());
    wait_idle();
    report_test("test 3 max/min", e0);
  endtask

  task automatic test_xchg_passb();
    int e0;
    e0 = errors;
    issue(2'b11, fpsu_pkg::OP_XCHG, 8'h40, rand_word(), rand_word(), rand_word(), rand_word());
    wait_idle();
    issue(2'b11, fpsu_pkg::OP_PASSB, 8'h41, rand_word(), rand_word(), rand_word(), rand_word());
    wait_idle();
    // saturate the high half so its held sat bits are visible.
    issue(2'b11, fpsu_pkg::OP_ADDS, 8'h42, rand_word(), rand_word(),
          32'h7fff_8000, 32'h0001_ffff);
    wait_idle();
    // a stale high-half tag would alter this tag when merged.
    issue(2'b01, fpsu_pkg::OP_PASSB, 8'h44, rand_word(), rand_word(), rand_word(), rand_word());
    wait_idle();
    report_test("test 4 exchange/pass-b", e0);
  endtask

  task automatic test_forwarding();
    int e0;
    e0 = errors;
    fwd_lo0 = rand_word();
    fwd_lo1 = rand_word();
    fwd_hi0 = rand_word();
    fwd_hi1 = rand_word();
    issue(2'b11, fpsu_pkg::OP_ADD, 8'h50, rand_word(), rand_word(), rand_word(), rand_word(),
          `FPSU_SEL_FWD0, `FPSU_SEL_FWD1);
    wait_idle();
    issue(2'b11, fpsu_pkg::OP_SUB, 8'h51, rand_word(), rand_word(), rand_word(), rand_word(),
          `FPSU_SEL_FWD1, `FPSU_SEL_FWD0);
    wait_idle();
    // accumulate through the own-result path.
    for (int i = 0; i < 3; i++) begin
      issue(2'b11, fpsu_pkg::OP_ADD, 8'h52 + 8'(i), rand_word(), rand_word(),
            rand_word(), rand_word(), `FPSU_SEL_OWN, `FPSU_SEL_REG);
      wait_idle();
    end
    report_test("test 5 forwarding", e0);
  endtask

  task automatic test_back_to_back();
    int            e0;
    fpsu_pkg::op_e ops [6];
    e0  = errors;
    ops = '{fpsu_pkg::OP_ADD, fpsu_pkg::OP_SUB, fpsu_pkg::OP_ADDS,
            fpsu_pkg::OP_MAX, fpsu_pkg::OP_MIN, fpsu_pkg::OP_PASSB};
    for (int i = 0; i < 6; i++) begin
      issue(2'b11, ops[i], 8'h60 + 8'(i), rand_word(), rand_word(), rand_word(), rand_word());
    end
    wait_idle();
    report_test("test 6 back-to-back", e0);
  endtask

  initial begin
    seed         = 32'h87a624c2;
    errors       = 0;
    checks       = 0;
    failed_tests = 0;
    rst_n        = 1'b0;
    en           = 2'b00;
    op           = fpsu_pkg::OP_ADD;
    tag          = '0;
    a_lo         = '0;
    b_lo         = '0;
    a_hi         = '0;
    b_hi         = '0;
    sel_a        = `FPSU_SEL_REG;
    sel_b        = `FPSU_SEL_REG;
    fwd_lo0      = '0;
    fwd_lo1      = '0;
    fwd_hi0      = '0;
    fwd_hi1      = '0;
    exp_lo       = '0;
    exp_hi       = '0;
    exp_sat      = '0;
    repeat (4) @(posedge clk);
    check_val("ret_en", 32'(ret_en), 32'd0);
    check_val("ret_tag", 32'(ret_tag), 32'd0);
    check_val("res_lo", res_lo, 32'd0);
    check_val("res_hi", res_hi, 32'd0);
    check_val("sat", 32'(sat), 32'd0);
    #2;
    rst_n = 1'b1;
    test_add_sub();
    test_sat_add();
    test_max_min();
    test_xchg_passb();
    test_forwarding();
    test_back_to_back();
    $display("tests: 6, failed: %0d, checks: %0d, errors: %0d", failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* fpsu.f */
+incdir+hw
hw/fpsu_pkg.sv
hw/fpsu_delay.sv
hw/fpsu_opnd_sel.sv
hw/fpsu_lane_alu.sv
hw/fpsu_half.sv
hw/fpsu_both.sv
sim/fpsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fpsu.f --top-module fpsu_tb -o fpsu_sim

out=$(./obj_dir/fpsu_sim)
echo "$out"

if echo "$out" | grep -q "^Simulation finished: PASS$"; then
  exit 0
else
  exit 1
fi
